//--- src/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path and address width
`define LSU_XLEN        64
`define LSU_ADDR_W      `LSU_XLEN

// fixed id on every transaction
`define LSU_ID_W        4
`define LSU_AXI_ID      4'h1

// sram model, read latency must be 2 or more
`define SRAM_DEPTH      256
`define SRAM_READ_LAT   2

// axi field encodings
`define AXI_BURST_INCR    2'b01
`define AXI_RESP_OKAY     2'b00
`define AXI_PROT_DATA     3'b000    // unprivileged, secure, data access
`define AXI_CACHE_NORMAL  4'b0010   // normal, non-cacheable, non-bufferable

`endif

//--- src/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    // access size, encoded the same way as axi size
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_e;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    // request word from the pipeline
    typedef struct packed {
        mem_op_e                write;
        mem_size_e              size;
        logic                   is_unsigned;    // zero-extend loads
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_XLEN-1:0]   wdata;          // store data, low bits
    } mem_req_t;

    // shared layout of the aw and ar channels
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_ID_W-1:0]   id;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
        logic [2:0]             prot;
        logic [3:0]             cache;
    } axi_ax_t;

    typedef axi_ax_t axi_aw_t;
    typedef axi_ax_t axi_ar_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   data;
        logic [`LSU_XLEN/8-1:0] strb;
        logic                   last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0]             resp;
        logic [`LSU_ID_W-1:0]   id;
    } axi_b_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   data;
        logic [1:0]             resp;
        logic                   last;
        logic [`LSU_ID_W-1:0]   id;
    } axi_r_t;

endpackage

//--- src/mem_stage.sv
`include "lsu_cfg.svh"
`timescale 1ns/1ps

module mem_stage (
    input  logic                    mem_valid_i,
    input  lsu_pkg::mem_req_t       mem_req_i,
    output logic                    mem_done_o,
    output logic [`LSU_XLEN-1:0]    mem_rdata_o,

    output logic                    bus_valid_o,
    output logic                    bus_write_o,
    output logic [`LSU_ADDR_W-1:0]  bus_addr_o,
    output logic [`LSU_XLEN-1:0]    bus_wdata_o,
    output logic [`LSU_XLEN/8-1:0]  bus_strb_o,
    output logic [2:0]              bus_size_o,
    input  logic                    bus_done_i,
    input  logic [`LSU_XLEN-1:0]    bus_rdata_i
);
    import lsu_pkg::*;

    logic [2:0]                 byte_off;
    logic [5:0]                 bit_off;
    logic [`LSU_XLEN/8-1:0]     size_mask;
    logic [`LSU_XLEN-1:0]       load_word;

    assign byte_off = mem_req_i.addr[2:0];
    assign bit_off  = {byte_off, 3'b000};

    // bytes touched by the access, before lane shift
    always_comb begin
        case (mem_req_i.size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    assign bus_valid_o = mem_valid_i;
    assign bus_write_o = (mem_req_i.write == MEM_STORE);
    assign bus_addr_o  = mem_req_i.addr;
    assign bus_size_o  = {1'b0, mem_req_i.size};   // enum matches axi size
    assign bus_strb_o  = size_mask << byte_off;
    assign bus_wdata_o = mem_req_i.wdata << bit_off;

    // bring the addressed lane down to bit 0
    assign load_word = bus_rdata_i >> bit_off;

    always_comb begin
        case (mem_req_i.size)
            SIZE_BYTE: begin
                if (mem_req_i.is_unsigned) begin
                    mem_rdata_o = {{(`LSU_XLEN-8){1'b0}}, load_word[7:0]};
                end else begin
                    mem_rdata_o = {{(`LSU_XLEN-8){load_word[7]}}, load_word[7:0]};
                end
            end
            SIZE_HALF: begin
                if (mem_req_i.is_unsigned) begin
                    mem_rdata_o = {{(`LSU_XLEN-16){1'b0}}, load_word[15:0]};
                end else begin
                    mem_rdata_o = {{(`LSU_XLEN-16){load_word[15]}}, load_word[15:0]};
                end
            end
            SIZE_WORD: begin
                if (mem_req_i.is_unsigned) begin  // lwu
                    mem_rdata_o = {{(`LSU_XLEN-32){1'b0}}, load_word[31:0]};
                end else begin
                    mem_rdata_o = {{(`LSU_XLEN-32){load_word[31]}}, load_word[31:0]};
                end
            end
            default: begin
                mem_rdata_o = load_word;    // doubleword, nothing to extend
            end
        endcase
    end

    assign mem_done_o = bus_done_i;

endmodule

//--- src/axi_ls.sv
`include "lsu_cfg.svh"
`timescale 1ns/1ps

module axi_ls (
    input  logic                    clock,
    input  logic                    reset,

    input  logic                    wr_valid_i,
    input  logic                    rd_valid_i,
    input  logic [`LSU_ADDR_W-1:0]  addr_i,
    input  logic [`LSU_XLEN-1:0]    wdata_i,
    input  logic [`LSU_XLEN/8-1:0]  wstrb_i,
    input  logic [2:0]              size_i,
    output logic                    wr_ok_o,
    output logic                    rd_ok_o,
    output logic [`LSU_XLEN-1:0]    rdata_o,

    output lsu_pkg::axi_aw_t        aw_o,
    output logic                    aw_valid_o,
    input  logic                    aw_ready_i,
    output lsu_pkg::axi_w_t         w_o,
    output logic                    w_valid_o,
    input  logic                    w_ready_i,
    input  lsu_pkg::axi_b_t         b_i,
    input  logic                    b_valid_i,
    output logic                    b_ready_o,
    output lsu_pkg::axi_ar_t        ar_o,
    output logic                    ar_valid_o,
    input  logic                    ar_ready_i,
    input  lsu_pkg::axi_r_t         r_i,
    input  logic                    r_valid_i,
    output logic                    r_ready_o
);
    import lsu_pkg::*;

    // gray coded, one bit changes per step
    localparam logic [1:0] W_IDLE = 2'b00;
    localparam logic [1:0] W_ADDR = 2'b01;
    localparam logic [1:0] W_DATA = 2'b11;
    localparam logic [1:0] W_RESP = 2'b10;

    localparam logic [1:0] R_IDLE = 2'b00;
    localparam logic [1:0] R_ADDR = 2'b01;
    localparam logic [1:0] R_DATA = 2'b11;
    localparam logic [1:0] R_DONE = 2'b10;

    logic [1:0]                 w_state;
    logic [1:0]                 w_state_next;
    logic [1:0]                 r_state;
    logic [1:0]                 r_state_next;
    logic [`LSU_ADDR_W-1:0]     addr_q;         // address of the last issued request
    logic                       addr_hit;
    logic                       wr_resp_q;      // b seen for this write
    logic [`LSU_XLEN-1:0]       rdata_q;
    logic                       aw_hs;
    logic                       w_hs;
    logic                       b_hs;
    logic                       ar_hs;
    logic                       r_hs;

    assign aw_hs    = aw_valid_o & aw_ready_i;
    assign w_hs     = w_valid_o & w_ready_i;
    assign b_hs     = b_valid_i & b_ready_o & (b_i.id == `LSU_AXI_ID);
    assign ar_hs    = ar_valid_o & ar_ready_i;
    assign r_hs     = r_valid_i & r_ready_o;
    assign addr_hit = (addr_i == addr_q);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state <= W_IDLE;
            r_state <= R_IDLE;
        end else begin
            w_state <= w_state_next;
            r_state <= r_state_next;
        end
    end

    always_comb begin
        w_state_next = w_state;
        case (w_state)
            W_IDLE: if (wr_valid_i) w_state_next = W_ADDR;
            W_ADDR: if (aw_hs) w_state_next = W_DATA;
            W_DATA: if (w_hs) w_state_next = W_RESP;
            default: begin
                if (!wr_valid_i) begin
                    w_state_next = W_IDLE;
                end else if (wr_resp_q && !addr_hit) begin
                    w_state_next = W_ADDR;  // new address, restart
                end
            end
        endcase
    end

    // cleared on any step out of the response state
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_resp_q <= 1'b0;
        end else if (w_state != W_RESP) begin
            wr_resp_q <= 1'b0;
        end else if (b_hs) begin
            wr_resp_q <= 1'b1;
        end
    end

    always_comb begin
        r_state_next = r_state;
        case (r_state)
            R_IDLE: if (rd_valid_i) r_state_next = R_ADDR;
            R_ADDR: if (ar_hs) r_state_next = R_DATA;
            R_DATA: if (r_hs) r_state_next = R_DONE;
            default: begin
                if (!rd_valid_i) begin
                    r_state_next = R_IDLE;
                end else if (!addr_hit) begin
                    r_state_next = R_ADDR;
                end
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (aw_hs || ar_hs) begin
            addr_q <= addr_i;
        end
        if (r_hs) begin
            rdata_q <= r_i.data;
        end
    end

    assign aw_valid_o = (w_state == W_ADDR);
    assign w_valid_o  = (w_state == W_DATA);
    assign b_ready_o  = (w_state == W_RESP) && !wr_resp_q;
    assign ar_valid_o = (r_state == R_ADDR);
    assign r_ready_o  = (r_state == R_DATA);

    // done only while the same request is still held
    assign wr_ok_o = (w_state == W_RESP) && wr_resp_q && wr_valid_i && addr_hit;
    assign rd_ok_o = (r_state == R_DONE) && rd_valid_i && addr_hit;
    assign rdata_o = rd_ok_o ? rdata_q : '0;

    // single beat, payload straight from the held request
    assign aw_o = '{addr: addr_i, id: `LSU_AXI_ID, len: 8'd0, size: size_i,
                    burst: `AXI_BURST_INCR, prot: `AXI_PROT_DATA, cache: `AXI_CACHE_NORMAL};
    assign ar_o = '{addr: addr_i, id: `LSU_AXI_ID, len: 8'd0, size: size_i,
                    burst: `AXI_BURST_INCR, prot: `AXI_PROT_DATA, cache: `AXI_CACHE_NORMAL};
    assign w_o  = '{data: wdata_i, strb: wstrb_i, last: 1'b1};

endmodule

//--- src/axi_sram_slave.sv
`include "lsu_cfg.svh"
`timescale 1ns/1ps

module axi_sram_slave (
    input  logic                clock,
    input  logic                reset,

    input  lsu_pkg::axi_aw_t    aw_i,
    input  logic                aw_valid_i,
    output logic                aw_ready_o,
    input  lsu_pkg::axi_w_t     w_i,
    input  logic                w_valid_i,
    output logic                w_ready_o,
    output lsu_pkg::axi_b_t     b_o,
    output logic                b_valid_o,
    input  logic                b_ready_i,
    input  lsu_pkg::axi_ar_t    ar_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    output lsu_pkg::axi_r_t     r_o,
    output logic                r_valid_o,
    input  logic                r_ready_i
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(`SRAM_DEPTH);
    localparam int CNT_W = $clog2(`SRAM_READ_LAT + 1);

    localparam logic [1:0] S_IDLE  = 2'b00;
    localparam logic [1:0] S_BRESP = 2'b01;
    localparam logic [1:0] S_RWAIT = 2'b11;
    localparam logic [1:0] S_RDATA = 2'b10;

    logic [`LSU_XLEN-1:0]   mem [0:`SRAM_DEPTH-1];
    logic [1:0]             state;
    logic [1:0]             state_next;
    logic [IDX_W-1:0]       widx_q;
    logic [IDX_W-1:0]       ridx_q;
    logic [`LSU_ID_W-1:0]   bid_q;
    logic [`LSU_ID_W-1:0]   rid_q;
    logic [CNT_W-1:0]       lat_cnt;
    logic [`LSU_XLEN-1:0]   rdata_q;
    logic                   aw_hs;
    logic                   w_hs;
    logic                   ar_hs;

    assign aw_hs = aw_valid_i & aw_ready_o;
    assign w_hs  = w_valid_i & w_ready_o;
    assign ar_hs = ar_valid_i & ar_ready_o;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (w_hs) begin
                    state_next = S_BRESP;
                end else if (ar_hs) begin
                    state_next = S_RWAIT;
                end
            end
            S_BRESP: if (b_ready_i) state_next = S_IDLE;
            S_RWAIT: if (lat_cnt <= CNT_W'(1)) state_next = S_RDATA;
            default: if (r_ready_i) state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state   <= S_IDLE;
            lat_cnt <= '0;
        end else begin
            state <= state_next;
            if (ar_hs) begin
                lat_cnt <= CNT_W'(`SRAM_READ_LAT - 1);
            end else if (state == S_RWAIT && lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // word index is addr[10:3] for 256 words
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            widx_q <= aw_i.addr[IDX_W+2:3];
            bid_q  <= aw_i.id;
        end
        if (ar_hs) begin
            ridx_q <= ar_i.addr[IDX_W+2:3];
            rid_q  <= ar_i.id;
        end
        if (state == S_RWAIT && state_next == S_RDATA) begin
            rdata_q <= mem[ridx_q];
        end
    end

    // byte-enable write
    always_ff @(posedge clock) begin
        if (w_hs) begin
            for (int i = 0; i < `LSU_XLEN/8; i++) begin
                if (w_i.strb[i]) begin
                    mem[widx_q][i*8 +: 8] <= w_i.data[i*8 +: 8];
                end
            end
        end
    end

    assign aw_ready_o = (state == S_IDLE);
    assign w_ready_o  = (state == S_IDLE);
    assign ar_ready_o = (state == S_IDLE);
    assign b_valid_o  = (state == S_BRESP);
    assign r_valid_o  = (state == S_RDATA);

    assign b_o = '{resp: `AXI_RESP_OKAY, id: bid_q};
    assign r_o = '{data: rdata_q, resp: `AXI_RESP_OKAY, last: 1'b1, id: rid_q};

endmodule

//--- src/lsu_top.sv
`include "lsu_cfg.svh"
`timescale 1ns/1ps

module lsu_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    mem_valid_i,
    input  lsu_pkg::mem_req_t       mem_req_i,
    output logic                    mem_done_o,
    output logic [`LSU_XLEN-1:0]    mem_rdata_o
);
    import lsu_pkg::*;

    logic                       bus_valid;
    logic                       bus_write;
    logic [`LSU_ADDR_W-1:0]     bus_addr;
    logic [`LSU_XLEN-1:0]       bus_wdata;
    logic [`LSU_XLEN/8-1:0]     bus_strb;
    logic [2:0]                 bus_size;
    logic [`LSU_XLEN-1:0]       bus_rdata;
    logic                       wr_ok;
    logic                       rd_ok;

    axi_aw_t    aw;
    axi_w_t     w;
    axi_b_t     b;
    axi_ar_t    ar;
    axi_r_t     r;
    logic       aw_valid, aw_ready;
    logic       w_valid, w_ready;
    logic       b_valid, b_ready;
    logic       ar_valid, ar_ready;
    logic       r_valid, r_ready;

    mem_stage mem_stage_i (
        .mem_valid_i    (mem_valid_i),
        .mem_req_i      (mem_req_i),
        .mem_done_o     (mem_done_o),
        .mem_rdata_o    (mem_rdata_o),
        .bus_valid_o    (bus_valid),
        .bus_write_o    (bus_write),
        .bus_addr_o     (bus_addr),
        .bus_wdata_o    (bus_wdata),
        .bus_strb_o     (bus_strb),
        .bus_size_o     (bus_size),
        .bus_done_i     (wr_ok | rd_ok),    // only one side is ever active
        .bus_rdata_i    (bus_rdata)
    );

    axi_ls axi_ls_i (
        .clock      (clock),
        .reset      (reset),
        .wr_valid_i (bus_valid & bus_write),
        .rd_valid_i (bus_valid & ~bus_write),
        .addr_i     (bus_addr),
        .wdata_i    (bus_wdata),
        .wstrb_i    (bus_strb),
        .size_i     (bus_size),
        .wr_ok_o    (wr_ok),
        .rd_ok_o    (rd_ok),
        .rdata_o    (bus_rdata),
        .aw_o       (aw),
        .aw_valid_o (aw_valid),
        .aw_ready_i (aw_ready),
        .w_o        (w),
        .w_valid_o  (w_valid),
        .w_ready_i  (w_ready),
        .b_i        (b),
        .b_valid_i  (b_valid),
        .b_ready_o  (b_ready),
        .ar_o       (ar),
        .ar_valid_o (ar_valid),
        .ar_ready_i (ar_ready),
        .r_i        (r),
        .r_valid_i  (r_valid),
        .r_ready_o  (r_ready)
    );

    axi_sram_slave axi_sram_slave_i (
        .clock      (clock),
        .reset      (reset),
        .aw_i       (aw),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_i        (w),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_o        (b),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_o        (r),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready)
    );

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clock_o
);
    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

endmodule

//--- verification/lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties (
    input logic clock,
    input logic reset,
    input logic aw_valid_i,
    input logic aw_ready_i,
    input logic w_valid_i,
    input logic w_ready_i,
    input logic b_valid_i,
    input logic b_ready_i,
    input logic ar_valid_i,
    input logic ar_ready_i,
    input logic r_valid_i,
    input logic r_ready_i,
    input logic wr_valid_i,
    input logic rd_valid_i,
    input logic wr_ok_i,
    input logic rd_ok_i
);

    // a valid waits for its ready on every channel
    aw_hold: assert property (@(posedge clock) disable iff (!reset)
        aw_valid_i && !aw_ready_i |=> aw_valid_i)
        else $error("aw_valid dropped before aw_ready");
    w_hold: assert property (@(posedge clock) disable iff (!reset)
        w_valid_i && !w_ready_i |=> w_valid_i)
        else $error("w_valid dropped before w_ready");
    b_hold: assert property (@(posedge clock) disable iff (!reset)
        b_valid_i && !b_ready_i |=> b_valid_i)
        else $error("b_valid dropped before b_ready");
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_i && !ar_ready_i |=> ar_valid_i)
        else $error("ar_valid dropped before ar_ready");
    r_hold: assert property (@(posedge clock) disable iff (!reset)
        r_valid_i && !r_ready_i |=> r_valid_i)
        else $error("r_valid dropped before r_ready");

    // write data follows aw and b_ready follows w
    w_after_aw: assert property (@(posedge clock) disable iff (!reset)
        $rose(w_valid_i) |-> $past(aw_valid_i && aw_ready_i))
        else $error("w_valid rose without an aw handshake");
    b_after_w: assert property (@(posedge clock) disable iff (!reset)
        $rose(b_ready_i) |-> $past(w_valid_i && w_ready_i))
        else $error("b_ready rose before the write address and data went out");
    r_after_ar: assert property (@(posedge clock) disable iff (!reset)
        $rose(r_ready_i) |-> $past(ar_valid_i && ar_ready_i))
        else $error("r_ready rose without an ar handshake");

    // done comes right after the response of a request that is still held
    wr_done_after_b: assert property (@(posedge clock) disable iff (!reset)
        $rose(wr_ok_i) |-> $past(b_valid_i && b_ready_i && wr_valid_i))
        else $error("write done rose without a b handshake on a held store");
    rd_done_after_r: assert property (@(posedge clock) disable iff (!reset)
        $rose(rd_ok_i) |-> $past(r_valid_i && r_ready_i && rd_valid_i))
        else $error("read done rose without an r handshake on a held load");

endmodule

bind axi_ls lsu_properties lsu_properties_i (
    .clock      (clock),
    .reset      (reset),
    .aw_valid_i (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .w_valid_i  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .b_valid_i  (b_valid_i),
    .b_ready_i  (b_ready_o),
    .ar_valid_i (ar_valid_o),
    .ar_ready_i (ar_ready_i),
    .r_valid_i  (r_valid_i),
    .r_ready_i  (r_ready_o),
    .wr_valid_i (wr_valid_i),
    .rd_valid_i (rd_valid_i),
    .wr_ok_i    (wr_ok_o),
    .rd_ok_i    (rd_ok_o)
);

//--- verification/lsu_tb.sv
`include "lsu_cfg.svh"
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD_NS  = 40;
    localparam int ACCESS_TIMEOUT = 40;     // cycles per access
    localparam int RAND_FILL      = 16;     // doublewords preset before random mix
    localparam int N_RANDOM       = 200;
    localparam int N_ACCESS       = 2 + 9 + 29 + 8 + RAND_FILL + N_RANDOM;

    logic                   clock;
    logic                   reset;
    logic                   mem_valid;
    mem_req_t               mem_req;
    logic                   mem_done;
    logic [`LSU_XLEN-1:0]   mem_rdata;

    logic [7:0]             ref_mem [0:`SRAM_DEPTH*8-1];  // byte image of the sram
    int                     n_errors = 0;
    int                     n_checks = 0;
    int                     n_tests = 0;
    int                     n_access = 0;
    int                     b_count;
    int                     done_b_count = 0;   // b handshakes seen when done rose
    integer                 seed = 32'hc20a_f1c6;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) tb_clock_i (.clock_o(clock));

    lsu_top lsu_top_i (
        .clock       (clock),
        .reset       (reset),
        .mem_valid_i (mem_valid),
        .mem_req_i   (mem_req),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata)
    );

    always @(posedge clock or negedge reset) begin
        if (!reset) begin
            b_count <= 0;
        end else if (lsu_top_i.b_valid && lsu_top_i.b_ready) begin
            b_count <= b_count + 1;
        end
    end

    function automatic mem_req_t make_req(input mem_op_e op, input mem_size_e size,
                                          input logic uns, input logic [63:0] addr,
                                          input logic [63:0] data);
        mem_req_t req;
        req.write       = op;
        req.size        = size;
        req.is_unsigned = uns;
        req.addr        = addr;
        req.wdata       = data;
        return req;
    endfunction

    function automatic void model_write(input mem_req_t req);
        int base;
        int nbytes;
        base   = int'(req.addr[10:0]);
        nbytes = 1 << req.size;
        for (int i = 0; i < nbytes; i++) begin
            ref_mem[base + i] = req.wdata[i*8 +: 8];  // store data sits in the low bytes
        end
    endfunction

    function automatic logic [`LSU_XLEN-1:0] expected_load(input mem_req_t req);
        int base;
        int nbytes;
        logic [`LSU_XLEN-1:0] val;
        base   = int'(req.addr[10:0]);
        nbytes = 1 << req.size;
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[i*8 +: 8] = ref_mem[base + i];
        end
        // sign bit is the top bit of the last byte read
        if (!req.is_unsigned && nbytes < 8 && val[nbytes*8-1]) begin
            for (int i = nbytes; i < 8; i++) begin
                val[i*8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
            n_errors++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (mem_done !== 1'b1 && cycles < ACCESS_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        done_b_count = b_count;
        n_access++;
        n_checks++;
        assert (mem_done === 1'b1) else begin
            $display("no done from the DUT within %0d cycles at t=%0t, address %h",
                     ACCESS_TIMEOUT, $time, mem_req.addr);
            n_errors++;
        end
    endtask

    task automatic take_result(input mem_req_t req);
        if (req.write == MEM_STORE) begin
            model_write(req);
        end else begin
            check_value("mem_rdata_o", expected_load(req), mem_rdata);
        end
    endtask

    task automatic do_access(input mem_req_t req);
        @(posedge clock);
        mem_valid <= 1'b1;
        mem_req   <= req;
        wait_done();
        take_result(req);
        @(posedge clock);
        mem_valid <= 1'b0;
    endtask

    // second request replaces the first while valid stays high
    task automatic switch_access(input mem_req_t req_a, input mem_req_t req_b);
        @(posedge clock);
        mem_valid <= 1'b1;
        mem_req   <= req_a;
        wait_done();
        take_result(req_a);
        @(posedge clock);
        mem_req <= req_b;
        @(negedge clock);
        n_checks++;
        assert (mem_done === 1'b0) else begin
            $display("done stayed high at t=%0t after the address changed", $time);
            n_errors++;
        end
        wait_done();
        take_result(req_b);
        @(posedge clock);
        mem_valid <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        $display("%s finished with %0d errors", name, n_errors - errs_before);
    endtask

    task automatic double_store_load();
        int errs;
        int b_before;
        errs     = n_errors;
        b_before = b_count;
        do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h100, 64'h0123_4567_89ab_cdef));
        n_checks++;
        assert (done_b_count == b_before + 1) else begin
            $display("write done at t=%0t came without a b handshake", $time);
            n_errors++;
        end
        do_access(make_req(MEM_LOAD, SIZE_DOUBLE, 1'b0, 64'h100, 64'h0));
        report_test("double_store_load", errs);
    endtask

    task automatic merge_sub_stores();
        int errs;
        errs = n_errors;
        // upper data bits are junk, strobes keep them out
        do_access(make_req(MEM_STORE, SIZE_BYTE, 1'b0, 64'h208, 64'hdead_beef_cafe_f0a5));
        do_access(make_req(MEM_STORE, SIZE_BYTE, 1'b0, 64'h209, 64'h1111_2222_3333_443c));
        do_access(make_req(MEM_STORE, SIZE_HALF, 1'b0, 64'h20a, 64'h5555_6666_7777_beef));
        do_access(make_req(MEM_STORE, SIZE_WORD, 1'b0, 64'h20c, 64'h9999_aaaa_1234_5678));
        do_access(make_req(MEM_LOAD, SIZE_DOUBLE, 1'b0, 64'h208, 64'h0));
        do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h210, 64'h0011_2233_4455_6677));
        do_access(make_req(MEM_STORE, SIZE_BYTE, 1'b0, 64'h217, 64'h7777_0000_0000_00e1));
        do_access(make_req(MEM_STORE, SIZE_HALF, 1'b0, 64'h212, 64'h0000_ffff_0000_c0de));
        do_access(make_req(MEM_LOAD, SIZE_DOUBLE, 1'b0, 64'h210, 64'h0));
        report_test("merge_sub_stores", errs);
    endtask

    task automatic extend_loads();
        int errs;
        int step;
        errs = n_errors;
        // every lane mixes set and clear sign bits
        do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h300, 64'h8070_ff01_7f80_00fe));
        for (int sz = 0; sz < 3; sz++) begin
            step = 1 << sz;
            for (int off = 0; off < 8; off += step) begin
                for (int u = 0; u < 2; u++) begin
                    do_access(make_req(MEM_LOAD, mem_size_e'(sz[1:0]), u[0],
                                       64'h300 + 64'(off), 64'h0));
                end
            end
        end
        report_test("extend_loads", errs);
    endtask

    task automatic switch_address();
        int errs;
        errs = n_errors;
        do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h400, 64'haaaa_0000_aaaa_0001));
        do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h408, 64'hbbbb_0000_bbbb_0002));
        switch_access(make_req(MEM_LOAD, SIZE_DOUBLE, 1'b0, 64'h400, 64'h0),
                      make_req(MEM_LOAD, SIZE_WORD, 1'b0, 64'h40c, 64'h0));
        switch_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h410, 64'hcccc_1234_cccc_5678),
                      make_req(MEM_STORE, SIZE_HALF, 1'b0, 64'h41e, 64'h0000_0000_0000_8001));
        do_access(make_req(MEM_LOAD, SIZE_DOUBLE, 1'b0, 64'h410, 64'h0));
        do_access(make_req(MEM_LOAD, SIZE_HALF, 1'b0, 64'h41e, 64'h0));
        report_test("switch_address", errs);
    endtask

    task automatic random_mix();
        int errs;
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [6:0]  off;
        logic [1:0]  sz;
        errs = n_errors;
        // preset the region so no load sees unwritten bytes
        for (int i = 0; i < RAND_FILL; i++) begin
            hi = $random(seed);
            lo = $random(seed);
            do_access(make_req(MEM_STORE, SIZE_DOUBLE, 1'b0, 64'h500 + 64'(i * 8), {hi, lo}));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r   = $random(seed);
            hi  = $random(seed);
            lo  = $random(seed);
            sz  = r[9:8];
            off = r[6:0] >> sz;
            off = off << sz;        // natural alignment
            do_access(make_req(r[12] ? MEM_STORE : MEM_LOAD, mem_size_e'(sz), r[13],
                               64'h500 + {57'd0, off}, {hi, lo}));
        end
        report_test("random_mix", errs);
    endtask

    initial begin
        mem_valid <= 1'b0;
        mem_req   <= '0;
        reset     <= 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        double_store_load();
        merge_sub_stores();
        extend_loads();
        switch_address();
        random_mix();
        $display("%0d tests, %0d accesses, %0d checks, %0d errors",
                 n_tests, n_access, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // each access gets 40 cycles
    initial begin
        #(N_ACCESS * 40 * CLK_PERIOD_NS);
        $display("watchdog expired at t=%0t before the tests finished", $time);
        $display("Test failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/lsu_pkg.sv
src/mem_stage.sv
src/axi_ls.sv
src/axi_sram_slave.sv
src/lsu_top.sv
verification/tb_clock.sv
verification/lsu_properties.sv
verification/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the lsu testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module lsu_tb -Mdir "$BUILD_DIR" -o lsu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/lsu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
